/* hdl/exec_pkg.sv */
package exec_pkg;

  // datapath and address width
  localparam int XLEN = 32;
  localparam int REG_IDX_W = 5;

  // only the low bits of operand b reach the shifter
  localparam int SHAMT_W = 5;

  localparam int INSTR_BYTES = 4;

  // operand stage, issue register, ALU register and result register
  // add up to three clocks from the sampling edge to res_vld
  localparam int EXEC_LATENCY = 3;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  typedef enum logic [4:0] {
    // register-register
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SLT,
    OP_SLTU,
    OP_XOR,
    OP_SRL,
    OP_SRA,
    OP_OR,
    OP_AND,
    // register-immediate
    OP_ADDI,
    OP_SLTI,
    OP_SLTIU,
    OP_XORI,
    OP_ORI,
    OP_ANDI,
    OP_SLLI,
    OP_SRLI,
    OP_SRAI,
    // upper immediate
    OP_LUI,
    OP_AUIPC,
    // jumps
    OP_JAL,
    OP_JALR,
    // conditional branches
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_BLTU,
    OP_BGEU
  } exec_op_t;

  // payload leaving the operand stage
  typedef struct packed {
    exec_op_t op;
    reg_idx_t rd;
    xlen_t    opa;
    xlen_t    opb;
    xlen_t    cmp_b;
    xlen_t    pc_seq;
    xlen_t    target;
  } issue_t;

  // payload written back
  typedef struct packed {
    logic     rd_wr;
    reg_idx_t rd;
    xlen_t    rd_data;
    xlen_t    pc_next;
  } result_t;

endpackage

/* hdl/exec_operand_sel.sv */
`timescale 1ns/1ps

module exec_operand_sel (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue_vld,
  input  exec_pkg::exec_op_t op,
  input  exec_pkg::reg_idx_t rd,
  input  exec_pkg::xlen_t    rs1_data,
  input  exec_pkg::xlen_t    rs2_data,
  input  exec_pkg::xlen_t    imm,
  input  exec_pkg::xlen_t    pc,
  output logic               out_vld,
  output exec_pkg::issue_t   out
);
  import exec_pkg::*;

  // immediate layouts seen by this stage, FMT_R means no immediate
  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_SH,
    FMT_B,
    FMT_J,
    FMT_U
  } imm_fmt_t;

  imm_fmt_t fmt;
  xlen_t    imm_ext;
  issue_t   nxt;

  always_comb begin
    case (op)
      OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_JALR: fmt = FMT_I;
      OP_SLLI, OP_SRLI, OP_SRAI:                                    fmt = FMT_SH;
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:             fmt = FMT_B;
      OP_JAL:                                                       fmt = FMT_J;
      OP_LUI, OP_AUIPC:                                             fmt = FMT_U;
      default:                                                      fmt = FMT_R;
    endcase
  end

  // the raw field sits in the low bits of imm, only U-format uses the whole word
  always_comb begin
    case (fmt)
      FMT_I:   imm_ext = {{(XLEN-12){imm[11]}}, imm[11:0]};
      FMT_SH:  imm_ext = {{(XLEN-SHAMT_W){1'b0}}, imm[SHAMT_W-1:0]};
      FMT_B:   imm_ext = {{(XLEN-13){imm[12]}}, imm[12:0]};
      FMT_J:   imm_ext = {{(XLEN-21){imm[20]}}, imm[20:0]};
      FMT_U:   imm_ext = imm;
      default: imm_ext = '0;
    endcase
  end

  always_comb begin
    nxt.op     = op;
    nxt.rd     = rd;
    nxt.cmp_b  = rs2_data;
    nxt.pc_seq = pc + XLEN'(INSTR_BYTES);

    // LUI adds its immediate to zero, AUIPC to the PC
    case (op)
      OP_LUI:   nxt.opa = '0;
      OP_AUIPC: nxt.opa = pc;
      default:  nxt.opa = rs1_data;
    endcase

    if (fmt == FMT_R || fmt == FMT_B) begin
      nxt.opb = rs2_data;
    end else begin
      nxt.opb = imm_ext;
    end

    // JALR is register relative, JAL and branches are PC relative
    if (op == OP_JALR) begin
      nxt.target = rs1_data + imm_ext;
    end else begin
      nxt.target = pc + imm_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= issue_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_vld) begin
      out <= nxt;
    end
  end

endmodule

/* hdl/exec_stage_reg.sv */
`timescale 1ns/1ps

module exec_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_vld,
  input  payload_t in_data,
  output logic     out_vld,
  output payload_t out_data
);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= in_vld;
    end
  end

  // payload holds its last value between strobes
  always_ff @(posedge clk) begin
    if (in_vld) begin
      out_data <= in_data;
    end
  end

endmodule

/* hdl/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_vld,
  input  exec_pkg::issue_t  in,
  output logic              out_vld,
  output exec_pkg::result_t out
);
  import exec_pkg::*;

  logic [SHAMT_W-1:0] shamt;
  xlen_t              alu_res;
  logic               slt_s;
  logic               slt_u;
  logic               br_eq;
  logic               br_lt_s;
  logic               br_lt_u;
  logic               taken;
  logic               is_branch;
  logic               is_jump;
  result_t            nxt;

  // SRA and SRAI also take just the low five bits
  assign shamt = in.opb[SHAMT_W-1:0];

  assign slt_s = $signed(in.opa) < $signed(in.opb);
  assign slt_u = in.opa < in.opb;

  // the branch comparator always sees rs2, never the immediate
  assign br_eq   = in.opa == in.cmp_b;
  assign br_lt_s = $signed(in.opa) < $signed(in.cmp_b);
  assign br_lt_u = in.opa < in.cmp_b;

  always_comb begin
    case (in.op)
      OP_SUB:               alu_res = in.opa - in.opb;
      OP_SLL, OP_SLLI:      alu_res = in.opa << shamt;
      OP_SLT, OP_SLTI:      alu_res = {{(XLEN-1){1'b0}}, slt_s};
      OP_SLTU, OP_SLTIU:    alu_res = {{(XLEN-1){1'b0}}, slt_u};
      OP_XOR, OP_XORI:      alu_res = in.opa ^ in.opb;
      OP_SRL, OP_SRLI:      alu_res = in.opa >> shamt;
      OP_SRA, OP_SRAI:      alu_res = $signed(in.opa) >>> shamt;
      OP_OR, OP_ORI:        alu_res = in.opa | in.opb;
      OP_AND, OP_ANDI:      alu_res = in.opa & in.opb;
      // ADD, ADDI, LUI and AUIPC all reduce to a plain sum
      default:              alu_res = in.opa + in.opb;
    endcase
  end

  always_comb begin
    is_branch = 1'b1;
    case (in.op)
      OP_BEQ:  taken = br_eq;
      OP_BNE:  taken = !br_eq;
      OP_BLT:  taken = br_lt_s;
      OP_BGE:  taken = !br_lt_s;
      OP_BLTU: taken = br_lt_u;
      OP_BGEU: taken = !br_lt_u;
      default: begin
        taken     = 1'b0;
        is_branch = 1'b0;
      end
    endcase
  end

  assign is_jump = (in.op == OP_JAL) || (in.op == OP_JALR);

  always_comb begin
    nxt.rd_wr = !is_branch;
    nxt.rd    = in.rd;

    // jumps link the address of the following instruction
    if (is_jump) begin
      nxt.rd_data = in.pc_seq;
    end else begin
      nxt.rd_data = alu_res;
    end

    if (in.op == OP_JALR) begin
      nxt.pc_next = {in.target[XLEN-1:1], 1'b0};
    end else if (in.op == OP_JAL || taken) begin
      nxt.pc_next = in.target;
    end else begin
      nxt.pc_next = in.pc_seq;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= in_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (in_vld) begin
      out <= nxt;
    end
  end

endmodule

/* hdl/riscv_exec.sv */
`timescale 1ns/1ps

module riscv_exec (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue_vld,
  input  exec_pkg::exec_op_t op,
  input  exec_pkg::reg_idx_t rd,
  input  exec_pkg::xlen_t    rs1_data,
  input  exec_pkg::xlen_t    rs2_data,
  input  exec_pkg::xlen_t    imm,
  input  exec_pkg::xlen_t    pc,
  output logic               res_vld,
  output logic               res_rd_wr,
  output exec_pkg::reg_idx_t res_rd,
  output exec_pkg::xlen_t    res_rd_data,
  output exec_pkg::xlen_t    res_pc_next
);
  import exec_pkg::*;

  logic    sel_vld;
  issue_t  sel_data;
  logic    iss_vld;
  issue_t  iss_data;
  logic    alu_vld;
  result_t alu_data;
  result_t res_data;

  exec_operand_sel u_operand_sel (
    .clk       (clk),
    .rst       (rst),
    .issue_vld (issue_vld),
    .op        (op),
    .rd        (rd),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .pc        (pc),
    .out_vld   (sel_vld),
    .out       (sel_data)
  );

  // breaks the path between operand muxing and the ALU
  exec_stage_reg #(.payload_t(issue_t)) u_issue_reg (
    .clk      (clk),
    .rst      (rst),
    .in_vld   (sel_vld),
    .in_data  (sel_data),
    .out_vld  (iss_vld),
    .out_data (iss_data)
  );

  exec_alu u_alu (
    .clk     (clk),
    .rst     (rst),
    .in_vld  (iss_vld),
    .in      (iss_data),
    .out_vld (alu_vld),
    .out     (alu_data)
  );

  exec_stage_reg #(.payload_t(result_t)) u_result_reg (
    .clk      (clk),
    .rst      (rst),
    .in_vld   (alu_vld),
    .in_data  (alu_data),
    .out_vld  (res_vld),
    .out_data (res_data)
  );

  assign res_rd_wr   = res_data.rd_wr;
  assign res_rd      = res_data.rd;
  assign res_rd_data = res_data.rd_data;
  assign res_pc_next = res_data.pc_next;

endmodule

/* verif/exec_properties.sv */
`timescale 1ns/1ps

module exec_properties (
  input logic            clk,
  input logic            rst,
  input logic            issue_vld,
  input logic            res_vld,
  input exec_pkg::xlen_t res_pc_next
);
  import exec_pkg::*;

  // res_vld rises on the EXEC_LATENCY-th edge after the sampling edge,
  // so it is first sampled high one edge later
  a_latency: assert property (@(posedge clk) disable iff (rst)
    issue_vld |-> ##(EXEC_LATENCY + 1) res_vld)
    else $error("no result %0d cycles after an issue", EXEC_LATENCY);

  // a result only ever follows an issue
  a_no_spurious: assert property (@(posedge clk) disable iff (rst)
    res_vld |-> $past(issue_vld, EXEC_LATENCY + 1))
    else $error("result strobe without a matching issue");

  a_reset_clears: assert property (@(posedge clk) rst |=> !res_vld)
    else $error("result strobe after reset");

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    res_vld |-> res_pc_next[1:0] == 2'b00)
    else $error("next pc %08h is not word aligned", res_pc_next);

endmodule

bind riscv_exec exec_properties u_exec_properties (
  .clk         (clk),
  .rst         (rst),
  .issue_vld   (issue_vld),
  .res_vld     (res_vld),
  .res_pc_next (res_pc_next)
);

/* verif/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb;
  import exec_pkg::*;

  typedef struct packed {
    exec_op_t op;
    reg_idx_t rd;
    xlen_t    rs1;
    xlen_t    rs2;
    xlen_t    imm;
    xlen_t    pc;
    logic     wr;
    xlen_t    data;
    xlen_t    pc_next;
  } vec_t;

  localparam int NUM_VECS = 32;
  localparam int DRAIN_TIMEOUT = 50;

  // columns: op, rd, rs1, rs2, imm, pc, then expected rd_wr, rd_data, pc_next
  // branch rows carry no meaningful rd_data
  localparam vec_t VECS [NUM_VECS] = '{
    '{OP_ADD,   5'd1,  32'hffffffff, 32'h2,        32'h0,      32'h100, 1'b1, 32'h1,        32'h104},
    '{OP_SUB,   5'd2,  32'h1,        32'h2,        32'h0,      32'h104, 1'b1, 32'hffffffff, 32'h108},
    '{OP_AND,   5'd3,  32'hf0f0f0f0, 32'hff00ff00, 32'h0,      32'h108, 1'b1, 32'hf000f000, 32'h10c},
    '{OP_OR,    5'd4,  32'hf0f0f0f0, 32'h0f0f0000, 32'h0,      32'h10c, 1'b1, 32'hfffff0f0, 32'h110},
    '{OP_XOR,   5'd5,  32'haaaaaaaa, 32'hffff0000, 32'h0,      32'h110, 1'b1, 32'h5555aaaa, 32'h114},
    '{OP_SLT,   5'd6,  32'hffffffff, 32'h1,        32'h0,      32'h114, 1'b1, 32'h1,        32'h118},
    '{OP_SLTU,  5'd7,  32'hffffffff, 32'h1,        32'h0,      32'h118, 1'b1, 32'h0,        32'h11c},
    '{OP_SLL,   5'd8,  32'h1,        32'h24,       32'h0,      32'h11c, 1'b1, 32'h10,       32'h120},
    '{OP_SRL,   5'd9,  32'h80000000, 32'hffffffe1, 32'h0,      32'h120, 1'b1, 32'h40000000, 32'h124},
    '{OP_SRA,   5'd10, 32'h80000000, 32'h24,       32'h0,      32'h124, 1'b1, 32'hf8000000, 32'h128},
    '{OP_ADDI,  5'd11, 32'h5,        32'h12345678, 32'hfff,    32'h128, 1'b1, 32'h4,        32'h12c},
    '{OP_SLTIU, 5'd12, 32'h7,        32'h0,        32'h800,    32'h12c, 1'b1, 32'h1,        32'h130},
    '{OP_SLLI,  5'd13, 32'h3,        32'h0,        32'h4,      32'h130, 1'b1, 32'h30,       32'h134},
    '{OP_SRLI,  5'd14, 32'hf0000000, 32'h0,        32'h8,      32'h134, 1'b1, 32'h00f00000, 32'h138},
    '{OP_SRAI,  5'd15, 32'hf0000000, 32'h0,        32'h8,      32'h138, 1'b1, 32'hfff00000, 32'h13c},
    '{OP_LUI,   5'd16, 32'h12345678, 32'h0,        32'habcde000, 32'h13c, 1'b1, 32'habcde000, 32'h140},
    '{OP_AUIPC, 5'd17, 32'h0,        32'h0,        32'h1000,   32'h140, 1'b1, 32'h1140,     32'h144},
    '{OP_JAL,   5'd18, 32'h0,        32'h0,        32'h100,    32'h144, 1'b1, 32'h148,      32'h244},
    '{OP_JAL,   5'd19, 32'h0,        32'h0,        32'h1ffff8, 32'h148, 1'b1, 32'h14c,      32'h140},
    '{OP_JALR,  5'd20, 32'h2000,     32'h0,        32'h5,      32'h14c, 1'b1, 32'h150,      32'h2004},
    '{OP_BEQ,   5'd21, 32'h5,        32'h5,        32'h10,     32'h150, 1'b0, 32'h0,        32'h160},
    '{OP_BEQ,   5'd22, 32'h5,        32'h6,        32'h10,     32'h154, 1'b0, 32'h0,        32'h158},
    '{OP_BNE,   5'd23, 32'h5,        32'h6,        32'h1ff0,   32'h158, 1'b0, 32'h0,        32'h148},
    '{OP_BNE,   5'd24, 32'h5,        32'h5,        32'h10,     32'h15c, 1'b0, 32'h0,        32'h160},
    '{OP_BLT,   5'd25, 32'hffffffff, 32'h1,        32'h10,     32'h160, 1'b0, 32'h0,        32'h170},
    '{OP_BLT,   5'd26, 32'h1,        32'hffffffff, 32'h10,     32'h164, 1'b0, 32'h0,        32'h168},
    '{OP_BGE,   5'd27, 32'h1,        32'hffffffff, 32'h10,     32'h168, 1'b0, 32'h0,        32'h178},
    '{OP_BGE,   5'd28, 32'hffffffff, 32'h1,        32'h10,     32'h16c, 1'b0, 32'h0,        32'h170},
    '{OP_BLTU,  5'd29, 32'h1,        32'hffffffff, 32'h10,     32'h170, 1'b0, 32'h0,        32'h180},
    '{OP_BLTU,  5'd30, 32'hffffffff, 32'h1,        32'h10,     32'h174, 1'b0, 32'h0,        32'h178},
    '{OP_BGEU,  5'd31, 32'hffffffff, 32'h1,        32'h10,     32'h178, 1'b0, 32'h0,        32'h188},
    '{OP_BGEU,  5'd0,  32'h1,        32'hffffffff, 32'h10,     32'h17c, 1'b0, 32'h0,        32'h180}
  };

  logic     clk;
  logic     rst;
  logic     issue_vld;
  exec_op_t op;
  reg_idx_t rd;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  xlen_t    imm;
  xlen_t    pc;
  logic     res_vld;
  logic     res_rd_wr;
  reg_idx_t res_rd;
  xlen_t    res_rd_data;
  xlen_t    res_pc_next;

  vec_t expected [$];
  int   wait_cycles;

  riscv_exec u_riscv_exec (
    .clk         (clk),
    .rst         (rst),
    .issue_vld   (issue_vld),
    .op          (op),
    .rd          (rd),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .pc          (pc),
    .res_vld     (res_vld),
    .res_rd_wr   (res_rd_wr),
    .res_rd      (res_rd),
    .res_rd_data (res_rd_data),
    .res_pc_next (res_pc_next)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %08h, expected %08h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  // registered outputs read at the rising edge still hold the previous cycle's values
  always @(posedge clk) begin
    vec_t exp_vec;
    if (res_vld === 1'b1) begin
      if (expected.size() == 0) begin
        $display("a result strobe arrived at %0t with no instruction outstanding", $time);
        stop_run();
      end else begin
        exp_vec = expected.pop_front();
        check_flag($sformatf("%s rd_wr", exp_vec.op.name()), res_rd_wr, exp_vec.wr);
        check_idx($sformatf("%s rd", exp_vec.op.name()), res_rd, exp_vec.rd);
        if (exp_vec.wr) begin
          check_word($sformatf("%s rd_data", exp_vec.op.name()), res_rd_data, exp_vec.data);
        end
        check_word($sformatf("%s pc_next", exp_vec.op.name()), res_pc_next, exp_vec.pc_next);
      end
    end
  end

  initial begin
    rst       = 1'b1;
    issue_vld = 1'b0;
    op        = OP_ADD;
    rd        = '0;
    rs1_data  = '0;
    rs2_data  = '0;
    imm       = '0;
    pc        = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    // whole table goes in back to back
    for (int i = 0; i < NUM_VECS; i++) begin
      @(negedge clk);
      issue_vld = 1'b1;
      op        = VECS[i].op;
      rd        = VECS[i].rd;
      rs1_data  = VECS[i].rs1;
      rs2_data  = VECS[i].rs2;
      imm       = VECS[i].imm;
      pc        = VECS[i].pc;
      expected.push_back(VECS[i]);
    end
    @(negedge clk);
    issue_vld = 1'b0;

    wait_cycles = 0;
    while (expected.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (expected.size() == 0) begin
      // idle long enough to catch a stray result strobe
      repeat (EXEC_LATENCY + 1) @(negedge clk);
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("timed out waiting for %0d missing result(s)", expected.size());
      stop_run();
    end
  end

endmodule

/* flist.f */
hdl/exec_pkg.sv
hdl/exec_operand_sel.sv
hdl/exec_stage_reg.sv
hdl/exec_alu.sv
hdl/riscv_exec.sv
verif/exec_properties.sv
verif/exec_tb.sv
